//--- dispatch.f
+incdir+.
isa_pkg.sv
pipe_pkg.sv
stage_reg.sv
regfile.sv
hazard_ctrl.sv
operand_select.sv
branch_resolve.sv
dispatch_top.sv
dispatch_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the dispatch testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module dispatch_tb -f dispatch.f -o dispatch_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "build failed, see build.log"
    exit 1
fi

./obj_dir/dispatch_sim > sim.log 2>&1
sim_status=$?
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status, see sim.log"
    exit 1
fi

if grep -qx "TEST OK" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "pass line missing from sim.log"
    exit 1
fi

//--- dispatch_tb.sv
`default_nettype none

`include "dispatch_defines.svh"

module dispatch_tb;

    localparam int NUM_ROWS        = 18;
    localparam int WATCHDOG_CYCLES = NUM_ROWS * 4 + 60;

    typedef struct packed {
        pipe_pkg::id_dispatch_t   id;
        isa_pkg::alu_op_t         ex_aluop;
        pipe_pkg::push_forward_t  ex_fwd;
        pipe_pkg::push_forward_t  mem_fwd;
        logic                     exp_stall;
        pipe_pkg::branch_update_t exp_upd;
        pipe_pkg::dispatch_ex_t   exp_ex;
    } row_t;

    logic                     clk = 1'b0;
    logic                     arst_n;
    pipe_pkg::id_dispatch_t   id_in;
    isa_pkg::alu_op_t         ex_aluop;
    pipe_pkg::push_forward_t  ex_fwd;
    pipe_pkg::push_forward_t  mem_fwd;
    logic                     wb_en;
    logic [`REG_ADDR_W-1:0]   wb_addr;
    logic [`DATA_W-1:0]       wb_data;
    logic                     stall;
    pipe_pkg::branch_update_t branch_upd;
    pipe_pkg::dispatch_ex_t   dispatch_ex;

    logic [`DATA_W-1:0] model [`NUM_REGS];  // mirror of the register file.
    row_t               rows [NUM_ROWS];
    int                 fill_count = 0;
    logic [31:0]        lfsr = 32'd99;

    always #5 clk = ~clk;

    dispatch_top dut0 (
        .clk         (clk),
        .arst_n      (arst_n),
        .id_in       (id_in),
        .ex_aluop    (ex_aluop),
        .ex_fwd      (ex_fwd),
        .mem_fwd     (mem_fwd),
        .wb_en       (wb_en),
        .wb_addr     (wb_addr),
        .wb_data     (wb_data),
        .stall       (stall),
        .branch_upd  (branch_upd),
        .dispatch_ex (dispatch_ex)
    );

    //////////////////////////////
    // helpers
    //////////////////////////////

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hD000_0001) : (s >> 1);  // galois, right shift.
    endfunction

    function automatic logic load_class(input isa_pkg::alu_op_t op);
        return op inside {isa_pkg::ALU_LD_B, isa_pkg::ALU_LD_H, isa_pkg::ALU_LD_W,
                          isa_pkg::ALU_LD_BU, isa_pkg::ALU_LD_HU, isa_pkg::ALU_LL_W,
                          isa_pkg::ALU_SC_W};
    endfunction

    function automatic logic [31:0] off16_inst(input logic [15:0] o);
        return {6'b0, o, 10'b0};
    endfunction

    // high ten bits go to inst[9:0].
    function automatic logic [31:0] off26_inst(input logic [25:0] o);
        return {6'b0, o[15:0], o[25:16]};
    endfunction

    function automatic pipe_pkg::push_forward_t fwd_of(input logic [4:0] a, input logic [31:0] d);
        pipe_pkg::push_forward_t f;
        f.reg_write_en   = 1'b1;
        f.reg_write_addr = a;
        f.reg_write_data = d;
        return f;
    endfunction

    function automatic pipe_pkg::id_dispatch_t build_id(
        input logic [31:0] pc, input logic [31:0] inst, input isa_pkg::alu_op_t op,
        input logic [31:0] imm, input logic en0, input logic [4:0] a0,
        input logic en1, input logic [4:0] a1, input logic [4:0] waddr,
        input logic pre_taken, input logic [31:0] pre_addr);
        pipe_pkg::id_dispatch_t id;
        id                = '0;
        id.inst_valid     = 1'b1;
        id.pc             = pc;
        id.inst           = inst;
        id.aluop          = op;
        id.imm            = imm;
        id.src[0].en      = en0;
        id.src[0].addr    = a0;
        id.src[1].en      = en1;
        id.src[1].addr    = a1;
        id.reg_write_en   = (waddr != 5'd0);
        id.reg_write_addr = waddr;
        id.pre_taken      = pre_taken;
        id.pre_addr       = pre_addr;
        return id;
    endfunction

    // forward priority, then regfile, then immediate.
    function automatic logic [31:0] src_value(input pipe_pkg::id_dispatch_t id, input int idx,
        input logic stalled, input pipe_pkg::push_forward_t exf,
        input pipe_pkg::push_forward_t memf);
        logic       en;
        logic [4:0] a;
        en = id.src[idx].en;
        a  = id.src[idx].addr;
        if (stalled) return '0;
        if (idx == 0 && id.aluop == isa_pkg::ALU_PCADDU12I) return id.pc;
        if (en && exf.reg_write_en && exf.reg_write_addr == a) return exf.reg_write_data;
        if (en && memf.reg_write_en && memf.reg_write_addr == a) return memf.reg_write_data;
        if (en) return model[a];
        return id.imm;
    endfunction

    function automatic row_t make_row(input pipe_pkg::id_dispatch_t id,
        input isa_pkg::alu_op_t op, input pipe_pkg::push_forward_t exf,
        input pipe_pkg::push_forward_t memf);
        row_t             r;
        logic [1:0][31:0] opnd;
        logic [31:0]      o16;
        logic [31:0]      o26;
        logic [31:0]      pc4;
        logic [31:0]      target;
        logic             branch;
        logic             taken;
        r          = '0;
        r.id       = id;
        r.ex_aluop = op;
        r.ex_fwd   = exf;
        r.mem_fwd  = memf;
        r.exp_stall = load_class(op)
            && ((id.src[0].en && id.src[0].addr == exf.reg_write_addr)
            || (id.src[1].en && id.src[1].addr == exf.reg_write_addr));
        for (int i = 0; i < 2; i++) begin
            opnd[i] = src_value(id, i, r.exp_stall, exf, memf);
        end
        o16    = {{14{id.inst[25]}}, id.inst[25:10], 2'b00};
        o26    = {{4{id.inst[9]}}, id.inst[9:0], id.inst[25:10], 2'b00};
        pc4    = id.pc + 32'd4;
        branch = 1'b1;
        taken  = 1'b0;
        target = id.pc + o16;
        case (id.aluop)
            isa_pkg::ALU_BEQ:  taken = (opnd[0] == opnd[1]);
            isa_pkg::ALU_BNE:  taken = (opnd[0] != opnd[1]);
            isa_pkg::ALU_BLT:  taken = ($signed(opnd[0]) < $signed(opnd[1]));
            isa_pkg::ALU_BGE:  taken = ($signed(opnd[0]) >= $signed(opnd[1]));
            isa_pkg::ALU_BLTU: taken = (opnd[0] < opnd[1]);
            isa_pkg::ALU_BGEU: taken = (opnd[0] >= opnd[1]);
            isa_pkg::ALU_B, isa_pkg::ALU_BL: begin
                taken  = 1'b1;
                target = id.pc + o26;
            end
            isa_pkg::ALU_JIRL: begin
                taken  = 1'b1;
                target = opnd[0] + o16;
            end
            default: branch = 1'b0;
        endcase
        if (branch && id.inst_valid && !r.exp_stall) begin
            r.exp_upd.update_en   = 1'b1;
            r.exp_upd.taken       = taken;
            r.exp_upd.flush       = (taken != id.pre_taken)
                                  || (taken && id.pre_taken && id.pre_addr != target);
            r.exp_upd.actual_addr = taken ? target : (id.pre_taken ? pc4 : 32'd0);
            r.exp_upd.pc          = id.pc;
        end
        if (!r.exp_stall) begin
            r.exp_ex.inst_valid     = id.inst_valid;
            r.exp_ex.pc             = id.pc;
            r.exp_ex.inst           = id.inst;
            r.exp_ex.aluop          = id.aluop;
            r.exp_ex.reg1           = opnd[0];
            r.exp_ex.reg2           = opnd[1];
            r.exp_ex.reg_write_en   = id.reg_write_en;
            r.exp_ex.reg_write_addr = id.reg_write_addr;
            r.exp_ex.link_data = (id.aluop inside {isa_pkg::ALU_BL, isa_pkg::ALU_JIRL}) ? pc4 : '0;
        end
        return r;
    endfunction

    //////////////////////////////
    // checks
    //////////////////////////////

    task automatic stop_on_error(input string line);
        $display("%s", line);
        $display("TEST FAILED");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_stall(input logic got, input logic exp, input string tag);
        if (got !== exp) begin
            stop_on_error($sformatf("Mismatch at %0t: %s stall got %b expected %b",
                $time, tag, got, exp));
        end
    endtask

    task automatic check_upd(input pipe_pkg::branch_update_t got,
        input pipe_pkg::branch_update_t exp, input string tag);
        if (got !== exp) begin
            stop_on_error($sformatf("Mismatch at %0t: %s branch_upd got %h expected %h",
                $time, tag, got, exp));
        end
    endtask

    task automatic check_ex(input pipe_pkg::dispatch_ex_t got,
        input pipe_pkg::dispatch_ex_t exp, input string tag);
        if (got !== exp) begin
            stop_on_error($sformatf("Mismatch at %0t: %s dispatch_ex got %h expected %h",
                $time, tag, got, exp));
        end
    endtask

    //////////////////////////////
    // stimulus
    //////////////////////////////

    task automatic preload_regs();
        logic [31:0] val;
        model[0] = '0;
        for (int r = 1; r < `NUM_REGS; r++) begin
            val = '0;
            for (int b = 0; b < 32; b++) begin
                val  = {val[30:0], lfsr[0]};
                lfsr = lfsr_step(lfsr);
            end
            model[r] = val;
            wb_en    = 1'b1;
            wb_addr  = r[`REG_ADDR_W-1:0];
            wb_data  = val;
            @(negedge clk);
        end
        wb_en = 1'b0;
    endtask

    task automatic add_row(input row_t r);
        rows[fill_count] = r;
        fill_count++;
    endtask

    task automatic build_table();
        pipe_pkg::id_dispatch_t  ld_dep;
        pipe_pkg::push_forward_t neg_ex;
        pipe_pkg::push_forward_t pos_mem;
        neg_ex  = fwd_of(5'd10, 32'hFFFF_FFF0);  // -16 signed, huge unsigned.
        pos_mem = fwd_of(5'd11, 32'h0000_0010);
        ld_dep  = build_id(32'h200, off16_inst(16'h0008), isa_pkg::ALU_BEQ, 0,
            1, 5'd2, 1, 5'd5, 5'd0, 0, 0);
        // plain reads and immediate.
        add_row(make_row(build_id(32'h100, 0, isa_pkg::ALU_ADD, 0, 1, 5'd3, 1, 5'd7, 5'd9, 0, 0),
            isa_pkg::ALU_NOP, '0, '0));
        add_row(make_row(build_id(32'h104, 0, isa_pkg::ALU_ADD, 32'h1234, 1, 5'd4, 0, 5'd0,
            5'd10, 0, 0), isa_pkg::ALU_NOP, '0, '0));
        // forwarding priority.
        add_row(make_row(build_id(32'h108, 0, isa_pkg::ALU_ADD, 0, 1, 5'd3, 1, 5'd8, 5'd11, 0, 0),
            isa_pkg::ALU_ADD, fwd_of(5'd3, 32'hAAAA_0001), fwd_of(5'd3, 32'hBBBB_0002)));
        add_row(make_row(build_id(32'h10C, 0, isa_pkg::ALU_ADD, 0, 1, 5'd3, 1, 5'd8, 5'd11, 0, 0),
            isa_pkg::ALU_ADD, fwd_of(5'd12, 32'h1), fwd_of(5'd8, 32'hBBBB_0003)));
        add_row(make_row(build_id(32'h110, 0, isa_pkg::ALU_ADD, 32'h777, 1, 5'd4, 0, 5'd3,
            5'd11, 0, 0), isa_pkg::ALU_ADD, fwd_of(5'd3, 32'h5), fwd_of(5'd3, 32'h6)));
        // load-use, then replay, then a load with no match.
        add_row(make_row(ld_dep, isa_pkg::ALU_LD_W, fwd_of(5'd5, 32'hDEAD_0005), '0));
        add_row(make_row(ld_dep, isa_pkg::ALU_NOP, '0, '0));
        add_row(make_row(build_id(32'h204, 0, isa_pkg::ALU_ADD, 0, 1, 5'd2, 1, 5'd6, 5'd14, 0, 0),
            isa_pkg::ALU_LD_BU, fwd_of(5'd7, 32'h7), '0));
        // conditional branches, every prediction case.
        add_row(make_row(build_id(32'h1000, off16_inst(16'h0010), isa_pkg::ALU_BLT, 0,
            1, 5'd10, 1, 5'd11, 5'd0, 1, 32'h1040), isa_pkg::ALU_ADD, neg_ex, pos_mem));
        add_row(make_row(build_id(32'h1010, off16_inst(16'h0010), isa_pkg::ALU_BLTU, 0,
            1, 5'd10, 1, 5'd11, 5'd0, 1, 32'h1050), isa_pkg::ALU_ADD, neg_ex, pos_mem));
        add_row(make_row(build_id(32'h1020, off16_inst(16'hFFF0), isa_pkg::ALU_BGE, 0,
            1, 5'd10, 1, 5'd11, 5'd0, 0, 0), isa_pkg::ALU_ADD, neg_ex, pos_mem));
        add_row(make_row(build_id(32'h1030, off16_inst(16'hFFF0), isa_pkg::ALU_BGEU, 0,
            1, 5'd10, 1, 5'd11, 5'd0, 0, 0), isa_pkg::ALU_ADD, neg_ex, pos_mem));
        add_row(make_row(build_id(32'h1040, off16_inst(16'h0020), isa_pkg::ALU_BEQ, 0,
            1, 5'd5, 1, 5'd5, 5'd0, 1, 32'h10C4), isa_pkg::ALU_NOP, '0, '0));  // wrong addr.
        add_row(make_row(build_id(32'h1044, off16_inst(16'h0020), isa_pkg::ALU_BNE, 0,
            1, 5'd5, 1, 5'd5, 5'd0, 0, 0), isa_pkg::ALU_NOP, '0, '0));
        // jumps and link.
        add_row(make_row(build_id(32'h2000, off26_inst(26'h3FF_FFFC), isa_pkg::ALU_B, 0,
            0, 5'd0, 0, 5'd0, 5'd0, 1, 32'h1FF0), isa_pkg::ALU_NOP, '0, '0));
        add_row(make_row(build_id(32'h2004, off26_inst(26'h000_0400), isa_pkg::ALU_BL, 0,
            0, 5'd0, 0, 5'd0, 5'd1, 0, 0), isa_pkg::ALU_NOP, '0, '0));
        add_row(make_row(build_id(32'h2008, off16_inst(16'h0004), isa_pkg::ALU_JIRL, 0,
            1, 5'd6, 0, 5'd0, 5'd1, 1, 0), isa_pkg::ALU_NOP, '0, '0));
        add_row(make_row(build_id(32'h3000, 0, isa_pkg::ALU_PCADDU12I, 32'h0001_2000,
            0, 5'd0, 0, 5'd0, 5'd15, 0, 0), isa_pkg::ALU_ADD, '0, '0));
        if (fill_count != NUM_ROWS) begin
            stop_on_error($sformatf("table holds %0d rows but %0d were planned",
                fill_count, NUM_ROWS));
        end
    endtask

    // entered on a falling edge, leaves on one.
    task automatic apply_row(input row_t r, input int n);
        string tag;
        tag      = $sformatf("row %0d", n);
        id_in    = r.id;
        ex_aluop = isa_pkg::ALU_NOP;
        ex_fwd   = '0;
        mem_fwd  = '0;
        @(negedge clk);
        id_in    = '0;
        ex_aluop = r.ex_aluop;
        ex_fwd   = r.ex_fwd;
        mem_fwd  = r.mem_fwd;
        #1;
        check_stall(stall, r.exp_stall, tag);
        check_upd(branch_upd, r.exp_upd, tag);
        @(negedge clk);
        check_ex(dispatch_ex, r.exp_ex, tag);
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        stop_on_error($sformatf("the run timed out after %0d cycles", WATCHDOG_CYCLES));
    end

    initial begin
        arst_n   = 1'b0;
        id_in    = '0;
        ex_aluop = isa_pkg::ALU_NOP;
        ex_fwd   = '0;
        mem_fwd  = '0;
        wb_en    = 1'b0;
        wb_addr  = '0;
        wb_data  = '0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        preload_regs();
        build_table();
        for (int n = 0; n < NUM_ROWS; n++) begin
            apply_row(rows[n], n);
        end
        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

//--- dispatch_top.sv
`default_nettype none

`include "dispatch_defines.svh"

module dispatch_top (
    input  logic                        clk,
    input  logic                        arst_n,
    input  pipe_pkg::id_dispatch_t      id_in,
    input  isa_pkg::alu_op_t            ex_aluop,
    input  pipe_pkg::push_forward_t     ex_fwd,
    input  pipe_pkg::push_forward_t     mem_fwd,
    input  logic                        wb_en,
    input  logic [`REG_ADDR_W-1:0]      wb_addr,
    input  logic [`DATA_W-1:0]          wb_data,
    output logic                        stall,
    output pipe_pkg::branch_update_t    branch_upd,
    output pipe_pkg::dispatch_ex_t      dispatch_ex
);

    pipe_pkg::id_dispatch_t             id_q;
    pipe_pkg::src_req_t [`NUM_SRC-1:0]  src_req;
    logic [`NUM_SRC-1:0][`DATA_W-1:0]   rf_data;
    logic [`NUM_SRC-1:0][`DATA_W-1:0]   operand;
    pipe_pkg::dispatch_ex_t             ex_pkt;

    stage_reg #(.payload_t(pipe_pkg::id_dispatch_t)) u_id_reg (
        .clk    (clk),
        .arst_n (arst_n),
        .hold   (stall),
        .bubble (1'b0),
        .d      (id_in),
        .q      (id_q)
    );

    hazard_ctrl u_hazard (
        .id       (id_q),
        .ex_aluop (ex_aluop),
        .ex_fwd   (ex_fwd),
        .stall    (stall),
        .src_req  (src_req)
    );

    regfile u_regfile (
        .clk     (clk),
        .arst_n  (arst_n),
        .rd_req  (src_req),
        .rd_data (rf_data),
        .wb_en   (wb_en),
        .wb_addr (wb_addr),
        .wb_data (wb_data)
    );

    for (genvar i = 0; i < `NUM_SRC; i++) begin : g_src
        operand_select #(.src_idx(i)) u_opsel (
            .id      (id_q),
            .stall   (stall),
            .ex_fwd  (ex_fwd),
            .mem_fwd (mem_fwd),
            .rf_data (rf_data[i]),
            .operand (operand[i])
        );
    end

    branch_resolve u_branch (
        .id         (id_q),
        .stall      (stall),
        .operand    (operand),
        .ex_pkt     (ex_pkt),
        .branch_upd (branch_upd)
    );

    stage_reg #(.payload_t(pipe_pkg::dispatch_ex_t)) u_ex_reg (
        .clk    (clk),
        .arst_n (arst_n),
        .hold   (1'b0),
        .bubble (stall),  // stalled slot goes out empty.
        .d      (ex_pkt),
        .q      (dispatch_ex)
    );

endmodule

`default_nettype wire

//--- branch_resolve.sv
`default_nettype none

`include "dispatch_defines.svh"

module branch_resolve (
    input  pipe_pkg::id_dispatch_t              id,
    input  logic                                stall,
    input  logic [`NUM_SRC-1:0][`DATA_W-1:0]    operand,
    output pipe_pkg::dispatch_ex_t              ex_pkt,
    output pipe_pkg::branch_update_t            branch_upd
);

    logic [`DATA_W-1:0] reg1;
    logic [`DATA_W-1:0] reg2;
    logic [`DATA_W-1:0] offs16;
    logic [`DATA_W-1:0] offs26;
    logic [`DATA_W-1:0] pc_next;
    logic [`DATA_W-1:0] target;
    logic               eq;
    logic               lt_s;
    logic               lt_u;
    logic               is_branch;
    logic               taken;
    logic               is_link;

    assign reg1    = operand[0];
    assign reg2    = operand[1];
    assign offs16  = isa_pkg::offs16(id.inst);
    assign offs26  = isa_pkg::offs26(id.inst);
    assign pc_next = id.pc + `DATA_W'(`INST_BYTES);

    assign eq   = (reg1 == reg2);
    assign lt_s = ($signed(reg1) < $signed(reg2));
    assign lt_u = (reg1 < reg2);  // bltu and bgeu.

    //////////////////////////////
    // outcome and target
    //////////////////////////////

    always_comb begin
        is_branch = 1'b1;
        taken     = 1'b0;
        target    = id.pc + offs16;
        case (id.aluop)
            isa_pkg::ALU_BEQ:  taken = eq;
            isa_pkg::ALU_BNE:  taken = !eq;
            isa_pkg::ALU_BLT:  taken = lt_s;
            isa_pkg::ALU_BGE:  taken = !lt_s;
            isa_pkg::ALU_BLTU: taken = lt_u;
            isa_pkg::ALU_BGEU: taken = !lt_u;
            isa_pkg::ALU_B, isa_pkg::ALU_BL: begin
                taken  = 1'b1;
                target = id.pc + offs26;
            end
            isa_pkg::ALU_JIRL: begin
                taken  = 1'b1;
                target = reg1 + offs16;  // register relative.
            end
            default: begin
                is_branch = 1'b0;
                target    = '0;
            end
        endcase
    end

    assign is_link = (id.aluop == isa_pkg::ALU_BL) || (id.aluop == isa_pkg::ALU_JIRL);

    //////////////////////////////
    // predictor check
    //////////////////////////////

    always_comb begin
        branch_upd = '0;
        if (is_branch && id.inst_valid && !stall) begin
            branch_upd.update_en = 1'b1;
            branch_upd.taken     = taken;
            branch_upd.flush     = (taken != id.pre_taken)
                                 || (taken && id.pre_taken && (id.pre_addr != target));
            if (taken) begin
                branch_upd.actual_addr = target;
            end else if (id.pre_taken) begin
                branch_upd.actual_addr = pc_next;  // back to fall-through.
            end
            branch_upd.pc = id.pc;
        end
    end

    always_comb begin
        ex_pkt.inst_valid     = id.inst_valid;
        ex_pkt.pc             = id.pc;
        ex_pkt.inst           = id.inst;
        ex_pkt.aluop          = id.aluop;
        ex_pkt.reg1           = reg1;
        ex_pkt.reg2           = reg2;
        ex_pkt.reg_write_en   = id.reg_write_en;
        ex_pkt.reg_write_addr = id.reg_write_addr;
        ex_pkt.link_data      = is_link ? pc_next : '0;
    end

endmodule

`default_nettype wire

//--- operand_select.sv
`default_nettype none

`include "dispatch_defines.svh"

module operand_select #(
    parameter int src_idx = 0
) (
    input  pipe_pkg::id_dispatch_t  id,
    input  logic                    stall,
    input  pipe_pkg::push_forward_t ex_fwd,
    input  pipe_pkg::push_forward_t mem_fwd,
    input  logic [`DATA_W-1:0]      rf_data,
    output logic [`DATA_W-1:0]      operand
);

    localparam bit USE_PC = (src_idx == 0);  // pcaddu12i feeds pc on reg1.

    logic                   rd_en;
    logic [`REG_ADDR_W-1:0] rd_addr;
    logic                   ex_hit;
    logic                   mem_hit;

    assign rd_en   = id.src[src_idx].en;
    assign rd_addr = id.src[src_idx].addr;

    assign ex_hit  = rd_en && ex_fwd.reg_write_en && (ex_fwd.reg_write_addr == rd_addr);
    assign mem_hit = rd_en && mem_fwd.reg_write_en && (mem_fwd.reg_write_addr == rd_addr);

    always_comb begin
        if (stall) begin
            operand = '0;
        end else if (USE_PC && (id.aluop == isa_pkg::ALU_PCADDU12I)) begin
            operand = id.pc;
        end else if (ex_hit) begin
            operand = ex_fwd.reg_write_data;   // youngest result wins.
        end else if (mem_hit) begin
            operand = mem_fwd.reg_write_data;
        end else if (rd_en) begin
            operand = rf_data;
        end else begin
            operand = id.imm;
        end
    end

endmodule

`default_nettype wire

//--- hazard_ctrl.sv
`default_nettype none

`include "dispatch_defines.svh"

module hazard_ctrl (
    input  pipe_pkg::id_dispatch_t              id,
    input  isa_pkg::alu_op_t                    ex_aluop,
    input  pipe_pkg::push_forward_t             ex_fwd,
    output logic                                stall,
    output pipe_pkg::src_req_t [`NUM_SRC-1:0]   src_req
);

    logic [`NUM_SRC-1:0] src_hit;  // source needs the ex result.

    always_comb begin
        for (int i = 0; i < `NUM_SRC; i++) begin
            src_hit[i] = id.src[i].en && (id.src[i].addr == ex_fwd.reg_write_addr);
        end
    end

    // load data is not ready until mem.
    assign stall = isa_pkg::is_load(ex_aluop) && (|src_hit);

    assign src_req = id.src;

    // invalid slots carry no read enables.
    always_comb begin
        a_stall_valid: assert final (!stall || id.inst_valid)
            else $error("hazard_ctrl: stall on an invalid slot");
    end

endmodule

`default_nettype wire

//--- regfile.sv
`default_nettype none

`include "dispatch_defines.svh"

module regfile (
    input  logic                                clk,
    input  logic                                arst_n,
    input  pipe_pkg::src_req_t [`NUM_SRC-1:0]   rd_req,
    output logic [`NUM_SRC-1:0][`DATA_W-1:0]    rd_data,
    input  logic                                wb_en,
    input  logic [`REG_ADDR_W-1:0]              wb_addr,
    input  logic [`DATA_W-1:0]                  wb_data
);

    logic [`DATA_W-1:0] regs [`NUM_REGS];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en && (wb_addr != '0)) begin
            regs[wb_addr] <= wb_data;  // r0 stays zero.
        end
    end

    // no write bypass, same-cycle read sees old data.
    always_comb begin
        for (int p = 0; p < `NUM_SRC; p++) begin
            rd_data[p] = rd_req[p].en ? regs[rd_req[p].addr] : '0;
        end
    end

    a_wb_r0: assert property (@(posedge clk) disable iff (!arst_n) wb_en |-> (wb_addr != '0))
        else $error("regfile: write to r0 requested");

endmodule

`default_nettype wire

//--- stage_reg.sv
`default_nettype none

module stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     hold,
    input  logic     bubble,
    input  payload_t d,
    output payload_t q
);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            q <= '0;
        end else if (hold) begin
            q <= q;
        end else if (bubble) begin
            q <= '0;  // empty slot.
        end else begin
            q <= d;
        end
    end

    // a held slot must not also be emptied.
    a_hold_bubble: assert property (@(posedge clk) disable iff (!arst_n) !(hold && bubble))
        else $error("stage_reg: hold and bubble both high");

endmodule

`default_nettype wire

//--- pipe_pkg.sv
`default_nettype none

`include "dispatch_defines.svh"

package pipe_pkg;

    typedef struct packed {
        logic                   en;
        logic [`REG_ADDR_W-1:0] addr;
    } src_req_t;

    //////////////////////////////
    // decode to dispatch
    //////////////////////////////

    typedef struct packed {
        logic                          inst_valid;
        logic [`DATA_W-1:0]            pc;
        logic [31:0]                   inst;
        isa_pkg::alu_op_t              aluop;
        logic [`DATA_W-1:0]            imm;
        src_req_t [`NUM_SRC-1:0]       src;      // index 0 is reg1.
        logic                          reg_write_en;
        logic [`REG_ADDR_W-1:0]        reg_write_addr;
        logic                          pre_taken;
        logic [`DATA_W-1:0]            pre_addr;
    } id_dispatch_t;

    // result pushed back from ex or mem.
    typedef struct packed {
        logic                   reg_write_en;
        logic [`REG_ADDR_W-1:0] reg_write_addr;
        logic [`DATA_W-1:0]     reg_write_data;
    } push_forward_t;

    //////////////////////////////
    // dispatch to execute
    //////////////////////////////

    typedef struct packed {
        logic                   inst_valid;
        logic [`DATA_W-1:0]     pc;
        logic [31:0]            inst;
        isa_pkg::alu_op_t       aluop;
        logic [`DATA_W-1:0]     reg1;
        logic [`DATA_W-1:0]     reg2;
        logic                   reg_write_en;
        logic [`REG_ADDR_W-1:0] reg_write_addr;
        logic [`DATA_W-1:0]     link_data;
    } dispatch_ex_t;

    typedef struct packed {
        logic               update_en;
        logic               taken;
        logic               flush;
        logic [`DATA_W-1:0] actual_addr;
        logic [`DATA_W-1:0] pc;
    } branch_update_t;

endpackage

`default_nettype wire

//--- isa_pkg.sv
`default_nettype none

`include "dispatch_defines.svh"

package isa_pkg;

    typedef enum logic [7:0] {
        ALU_NOP       = 8'h00,
        ALU_ADD       = 8'h01,
        ALU_PCADDU12I = 8'h02,
        // load class, all can stall a dependent.
        ALU_LD_B      = 8'h10,
        ALU_LD_H      = 8'h11,
        ALU_LD_W      = 8'h12,
        ALU_LD_BU     = 8'h13,
        ALU_LD_HU     = 8'h14,
        ALU_LL_W      = 8'h15,
        ALU_SC_W      = 8'h16,
        // branches.
        ALU_BEQ       = 8'h20,
        ALU_BNE       = 8'h21,
        ALU_BLT       = 8'h22,
        ALU_BGE       = 8'h23,
        ALU_BLTU      = 8'h24,
        ALU_BGEU      = 8'h25,
        ALU_B         = 8'h26,
        ALU_BL        = 8'h27,
        ALU_JIRL      = 8'h28
    } alu_op_t;

    function automatic logic is_load(input alu_op_t op);
        return op inside {ALU_LD_B, ALU_LD_H, ALU_LD_W, ALU_LD_BU, ALU_LD_HU, ALU_LL_W, ALU_SC_W};
    endfunction

    // inst[25:10], word offset.
    function automatic logic [`DATA_W-1:0] offs16(input logic [31:0] inst);
        return {{(`DATA_W-18){inst[25]}}, inst[25:10], 2'b00};
    endfunction

    // inst[9:0] is the high part here.
    function automatic logic [`DATA_W-1:0] offs26(input logic [31:0] inst);
        return {{(`DATA_W-28){inst[9]}}, inst[9:0], inst[25:10], 2'b00};
    endfunction

endpackage

`default_nettype wire

//--- dispatch_defines.svh
`ifndef DISPATCH_DEFINES_SVH
`define DISPATCH_DEFINES_SVH

//////////////////////////////
// datapath widths
//////////////////////////////

`define DATA_W      32                  // data and pc width.
`define REG_ADDR_W  5
`define NUM_REGS    (1 << `REG_ADDR_W)  // architectural registers.

//////////////////////////////
// dispatch shape
//////////////////////////////

`define NUM_SRC     2                   // source operands per instruction.
`define INST_BYTES  4                   // pc step, also the link offset.

`endif
